// ==== Bender.yml ====
package:
  name: sram_ctrl

sources:
  - sram_ctrl_pkg.sv
  - sram_write_fifo.sv
  - sram_read_fifo.sv
  - sram_bus_sequencer.sv
  - sram_ctrl_top.sv
  - target: simulation
    files:
      - sram_async_model.sv
      - sram_ctrl_assertions.sv
      - tb_sram_ctrl.sv

// ==== filelist.f ====
sram_ctrl_pkg.sv
sram_write_fifo.sv
sram_read_fifo.sv
sram_bus_sequencer.sv
sram_ctrl_top.sv
sram_async_model.sv
sram_ctrl_assertions.sv
tb_sram_ctrl.sv

// ==== sram_async_model.sv ====
`default_nettype none

module sram_async_model (
  input  wire                  rst,
  input  wire                  sram_ce_b,
  input  wire                  sram_we_b,
  input  wire                  sram_oe_b,
  input  wire sram_ctrl_pkg::addr_t sram_addr,
  inout  wire sram_ctrl_pkg::data_t sram_data
);
  timeunit 1ns;
  timeprecision 100ps;
  import sram_ctrl_pkg::*;

  // chip timing in ns
  localparam realtime T_AA  = 15.0;
  localparam realtime T_DOE = 8.0;
  localparam realtime T_OHZ = 3.0;
  localparam realtime T_AW  = 8.0;

  data_t mem [1 << ADDR_W];
  logic  written [1 << ADDR_W];

  data_t out_word;
  logic  out_en;
  addr_t rd_addr_seen;

  initial begin
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      written[i] = 1'b0;
    end
    out_en = 1'b0;
  end

  // data unknown until tAA after the address or oe moves
  always @(sram_addr or negedge sram_oe_b) begin
    out_word = 'x;
    out_word <= #(T_AA) mem[sram_addr];
  end

  // output buffer turns on late and off a little late
  always @(sram_oe_b or sram_ce_b or sram_we_b) begin
    if (sram_oe_b === 1'b0 && sram_ce_b === 1'b0 && sram_we_b === 1'b1) begin
      out_en <= #(T_DOE) 1'b1;
    end else begin
      out_en <= #(T_OHZ) 1'b0;
    end
  end

  assign sram_data = out_en ? out_word : 'z;

  // write lands tAW into the pulse
  always @(negedge sram_we_b) begin
    #(T_AW);
    if (!rst && sram_we_b === 1'b0 && sram_ce_b === 1'b0) begin
      mem[sram_addr]     = sram_data;
      written[sram_addr] = 1'b1;
    end else if (!rst) begin
      $error("sram model: write pulse shorter than tAW");
    end
  end

  // write protocol
  always @(sram_addr) begin
    if (!rst && sram_we_b === 1'b0) begin
      $error("sram model: address changed while we low");
    end
  end

  always @(sram_data) begin
    if (!rst && sram_we_b === 1'b0) begin
      $error("sram model: data changed while we low");
    end
    // another driver fighting the model shows up as a mismatch
    if (!rst && out_en && !$isunknown(out_word) && sram_data !== out_word) begin
      $error("sram model: bus contention on sram_data");
    end
  end

  // read address held for the whole oe low window
  always @(negedge sram_oe_b) begin
    #1;
    rd_addr_seen = sram_addr;
    if (!rst && !written[sram_addr]) begin
      $error("sram model: read from unwritten word %h", sram_addr);
    end
  end

  always @(posedge sram_oe_b) begin
    if (!rst && sram_addr !== rd_addr_seen) begin
      $error("sram model: address changed during read");
    end
  end

endmodule

`default_nettype wire

// ==== sram_bus_sequencer.sv ====
`default_nettype none

module sram_bus_sequencer #(
  parameter int RD_WAIT_CYCLES  = sram_ctrl_pkg::DEF_RD_WAIT_CYCLES,
  parameter int WR_PULSE_CYCLES = sram_ctrl_pkg::DEF_WR_PULSE_CYCLES
) (
  input  logic                 oe_n,
  input  logic                 rst,
  input  logic                 wr_pending,
  input  sram_ctrl_pkg::addr_t wr_head_addr,
  input  sram_ctrl_pkg::data_t wr_head_data,
  input  logic                 rd_pending,
  input  sram_ctrl_pkg::addr_t rd_head_addr,
  output logic                 wr_pop,
  output logic                 rd_pop,
  output logic                 rd_done,
  output sram_ctrl_pkg::data_t rd_result,
  output logic                 sram_ce_b,
  output logic                 sram_we_b,
  output logic                 sram_oe_b,
  output sram_ctrl_pkg::addr_t sram_addr,
  inout  wire sram_ctrl_pkg::data_t sram_data
);
  import sram_ctrl_pkg::*;

  // longest phase index in any timed state
  localparam int PHASE_MAX = (RD_WAIT_CYCLES > WR_PULSE_CYCLES - 1) ?
                             RD_WAIT_CYCLES : WR_PULSE_CYCLES - 1;
  localparam int CNT_W = $clog2(PHASE_MAX + 2);

  // last phase of RD_ACCESS and WR_PULSE
  localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(RD_WAIT_CYCLES);
  localparam logic [CNT_W-1:0] WR_LAST = CNT_W'(WR_PULSE_CYCLES - 1);

  seq_state_t state;
  seq_state_t state_next;
  logic [CNT_W-1:0] phase;

  // bus write driver enable and its word
  logic drive_en;
  data_t wr_word;

  logic start_wr;
  logic start_rd;

  // writes always beat reads out of idle
  assign start_wr = (state == IDLE) && wr_pending;
  assign start_rd = (state == IDLE) && !wr_pending && rd_pending;

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE: begin
        if (start_wr) begin
          state_next = WR_SETUP;
        end else if (start_rd) begin
          state_next = RD_ACCESS;
        end
      end
      // address and data settle before we falls
      WR_SETUP: state_next = WR_PULSE;
      WR_PULSE: begin
        if (phase == WR_LAST) begin
          state_next = WR_HOLD;
        end
      end
      // data held one cycle past we rising
      WR_HOLD: state_next = IDLE;
      RD_ACCESS: begin
        if (phase == RD_LAST) begin
          state_next = RD_TURN;
        end
      end
      // bus released before anyone drives again
      RD_TURN: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // all pins come from flops, decoded from the next state
  always_ff @(posedge oe_n) begin
    if (rst) begin
      state     <= IDLE;
      phase     <= '0;
      sram_ce_b <= 1'b1;
      sram_we_b <= 1'b1;
      sram_oe_b <= 1'b1;
      drive_en  <= 1'b0;
      wr_pop    <= 1'b0;
      rd_pop    <= 1'b0;
    end else begin
      state <= state_next;
      // phase restarts on every state change
      if ((state_next != state) || (state == IDLE)) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
      sram_ce_b <= (state_next == IDLE) || (state_next == RD_TURN);
      sram_we_b <= (state_next != WR_PULSE);
      sram_oe_b <= (state_next != RD_ACCESS);
      drive_en  <= state_next inside {WR_SETUP, WR_PULSE, WR_HOLD};
      // pops land in WR_SETUP and the first RD_ACCESS cycle
      wr_pop    <= start_wr;
      rd_pop    <= start_rd;
    end
  end

  // address and write word captured at the start of an access
  always_ff @(posedge oe_n) begin
    if (start_wr) begin
      sram_addr <= wr_head_addr;
      wr_word   <= wr_head_data;
    end else if (start_rd) begin
      sram_addr <= rd_head_addr;
    end
  end

  // only write states drive, oe is high through all of them
  assign sram_data = drive_en ? wr_word : 'z;

  // read FIFO samples the bus on the last RD_ACCESS edge
  assign rd_done   = (state == RD_ACCESS) && (phase == RD_LAST);
  assign rd_result = sram_data;

endmodule

`default_nettype wire

// ==== sram_ctrl_assertions.sv ====
`default_nettype none

module sram_ctrl_assertions (
  input wire                        oe_n,
  input wire                        rst,
  input wire                        sram_ce_b,
  input wire                        sram_we_b,
  input wire                        sram_oe_b,
  input wire sram_ctrl_pkg::addr_t  sram_addr,
  input wire                        drive_en
);
  timeunit 1ns;
  timeprecision 100ps;

  // never read and write strobes at once
  a_no_oe_we: assert property (@(posedge oe_n) disable iff (rst)
    !(!sram_oe_b && !sram_we_b)) else $error("oe and we low together");

  // address frozen across the write pulse
  a_addr_stable: assert property (@(posedge oe_n) disable iff (rst)
    !sram_we_b |=> (sram_we_b || $stable(sram_addr))) else $error("addr moved in write");

  // no controller drive while the chip may drive
  a_no_drive_rd: assert property (@(posedge oe_n) disable iff (rst)
    !sram_oe_b |-> !drive_en) else $error("bus driven with oe low");

  // strobes idle after reset
  a_reset_idle: assert property (@(posedge oe_n)
    rst |=> (sram_ce_b && sram_we_b && sram_oe_b)) else $error("strobes not idle");

endmodule

bind sram_bus_sequencer sram_ctrl_assertions u_assertions (
  .oe_n     (oe_n),
  .rst      (rst),
  .sram_ce_b(sram_ce_b),
  .sram_we_b(sram_we_b),
  .sram_oe_b(sram_oe_b),
  .sram_addr(sram_addr),
  .drive_en (drive_en)
);

`default_nettype wire

// ==== sram_ctrl_pkg.sv ====
`default_nettype none

package sram_ctrl_pkg;

  // geometry of the external chip
  parameter int ADDR_W = 10;
  parameter int DATA_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // credits held or owed, also fifo occupancy
  typedef logic [3:0] credit_t;

  // bus sequencer phases
  typedef enum logic [2:0] {
    IDLE,
    WR_SETUP,
    WR_PULSE,
    WR_HOLD,
    RD_ACCESS,
    RD_TURN
  } seq_state_t;

  // per-path entries, also credits granted after reset
  parameter int DEF_FIFO_DEPTH = 4;

  // oe_n cycles from address and oe low to data sample
  parameter int DEF_RD_WAIT_CYCLES = 2;

  // oe_n cycles with we low
  parameter int DEF_WR_PULSE_CYCLES = 1;

  // up/down step for occupancy and credit counters
  function automatic credit_t credit_step(credit_t value, logic up, logic down);
    return value + credit_t'(up) - credit_t'(down);
  endfunction

endpackage

`default_nettype wire

// ==== sram_ctrl_top.sv ====
`default_nettype none

module sram_ctrl_top #(
  parameter int FIFO_DEPTH      = sram_ctrl_pkg::DEF_FIFO_DEPTH,
  parameter int RD_WAIT_CYCLES  = sram_ctrl_pkg::DEF_RD_WAIT_CYCLES,
  parameter int WR_PULSE_CYCLES = sram_ctrl_pkg::DEF_WR_PULSE_CYCLES
) (
  input  logic                 oe_n,
  input  logic                 rst,
  // write channel
  input  logic                 wr_valid,
  input  sram_ctrl_pkg::addr_t wr_addr,
  input  sram_ctrl_pkg::data_t wr_data,
  output logic                 wr_credit_return,
  // read request channel
  input  logic                 rd_valid,
  input  sram_ctrl_pkg::addr_t rd_addr,
  output logic                 rd_credit_return,
  // response channel
  output logic                 rsp_valid,
  output sram_ctrl_pkg::data_t rsp_data,
  input  logic                 rsp_credit,
  // chip pins
  output logic                 sram_ce_b,
  output logic                 sram_we_b,
  output logic                 sram_oe_b,
  output sram_ctrl_pkg::addr_t sram_addr,
  inout  wire sram_ctrl_pkg::data_t sram_data
);
  import sram_ctrl_pkg::*;

  // write path to sequencer
  logic  wr_pending;
  addr_t wr_head_addr;
  data_t wr_head_data;
  logic  wr_pop;

  // read path to and from sequencer
  logic  rd_pending;
  addr_t rd_head_addr;
  logic  rd_pop;
  logic  rd_done;
  data_t rd_result;

  sram_write_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_write_fifo (
    .oe_n            (oe_n),
    .rst             (rst),
    .wr_valid        (wr_valid),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .wr_pop          (wr_pop),
    .wr_pending      (wr_pending),
    .wr_head_addr    (wr_head_addr),
    .wr_head_data    (wr_head_data),
    .wr_credit_return(wr_credit_return)
  );

  sram_read_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_read_fifo (
    .oe_n            (oe_n),
    .rst             (rst),
    .rd_valid        (rd_valid),
    .rd_addr         (rd_addr),
    .rd_pop          (rd_pop),
    .rd_done         (rd_done),
    .rd_result       (rd_result),
    .rsp_credit      (rsp_credit),
    .rd_pending      (rd_pending),
    .rd_head_addr    (rd_head_addr),
    .rd_credit_return(rd_credit_return),
    .rsp_valid       (rsp_valid),
    .rsp_data        (rsp_data)
  );

  sram_bus_sequencer #(
    .RD_WAIT_CYCLES (RD_WAIT_CYCLES),
    .WR_PULSE_CYCLES(WR_PULSE_CYCLES)
  ) u_bus_sequencer (
    .oe_n        (oe_n),
    .rst         (rst),
    .wr_pending  (wr_pending),
    .wr_head_addr(wr_head_addr),
    .wr_head_data(wr_head_data),
    .rd_pending  (rd_pending),
    .rd_head_addr(rd_head_addr),
    .wr_pop      (wr_pop),
    .rd_pop      (rd_pop),
    .rd_done     (rd_done),
    .rd_result   (rd_result),
    .sram_ce_b   (sram_ce_b),
    .sram_we_b   (sram_we_b),
    .sram_oe_b   (sram_oe_b),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data)
  );

endmodule

`default_nettype wire

// ==== sram_read_fifo.sv ====
`default_nettype none

module sram_read_fifo #(
  parameter int FIFO_DEPTH = sram_ctrl_pkg::DEF_FIFO_DEPTH
) (
  input  logic                 oe_n,
  input  logic                 rst,
  input  logic                 rd_valid,
  input  sram_ctrl_pkg::addr_t rd_addr,
  input  logic                 rd_pop,
  input  logic                 rd_done,
  input  sram_ctrl_pkg::data_t rd_result,
  input  logic                 rsp_credit,
  output logic                 rd_pending,
  output sram_ctrl_pkg::addr_t rd_head_addr,
  output logic                 rd_credit_return,
  output logic                 rsp_valid,
  output sram_ctrl_pkg::data_t rsp_data
);
  import sram_ctrl_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // queued read addresses
  addr_t req_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] req_wr_ptr;
  logic [PTR_W-1:0] req_rd_ptr;
  credit_t req_count;

  // completed results waiting for delivery
  data_t res_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] res_wr_ptr;
  logic [PTR_W-1:0] res_rd_ptr;
  credit_t res_count;

  // credits granted by the consumer and reads holding one
  credit_t rsp_credits;
  credit_t in_flight;

  logic deliver;
  data_t res_head;

  // empty result queue passes rd_result straight through
  assign res_head = (res_count != '0) ? res_mem[res_rd_ptr] : rd_result;
  assign deliver  = ((res_count != '0) || rd_done) && (rsp_credits != '0);

  // issue only while a credit is still unreserved
  assign rd_pending       = (req_count != '0) && (in_flight < rsp_credits);
  assign rd_head_addr     = req_mem[req_rd_ptr];
  assign rd_credit_return = rd_pop;

  always_ff @(posedge oe_n) begin
    if (rd_valid) begin
      req_mem[req_wr_ptr] <= rd_addr;
    end
    // written every completion, bypassed slot is simply popped too
    if (rd_done) begin
      res_mem[res_wr_ptr] <= rd_result;
    end
    if (deliver) begin
      rsp_data <= res_head;
    end
  end

  always_ff @(posedge oe_n) begin
    if (rst) begin
      req_wr_ptr  <= '0;
      req_rd_ptr  <= '0;
      req_count   <= '0;
      res_wr_ptr  <= '0;
      res_rd_ptr  <= '0;
      res_count   <= '0;
      rsp_credits <= '0;
      in_flight   <= '0;
      rsp_valid   <= 1'b0;
    end else begin
      req_wr_ptr  <= req_wr_ptr + PTR_W'(rd_valid);
      req_rd_ptr  <= req_rd_ptr + PTR_W'(rd_pop);
      req_count   <= credit_step(req_count, rd_valid, rd_pop);
      res_wr_ptr  <= res_wr_ptr + PTR_W'(rd_done);
      res_rd_ptr  <= res_rd_ptr + PTR_W'(deliver);
      res_count   <= credit_step(res_count, rd_done, deliver);
      rsp_credits <= credit_step(rsp_credits, rsp_credit, deliver);
      in_flight   <= credit_step(in_flight, rd_pop, deliver);
      // one response per cycle
      rsp_valid   <= deliver;
    end
  end

endmodule

`default_nettype wire

// ==== sram_write_fifo.sv ====
`default_nettype none

module sram_write_fifo #(
  parameter int FIFO_DEPTH = sram_ctrl_pkg::DEF_FIFO_DEPTH
) (
  input  logic                 oe_n,
  input  logic                 rst,
  input  logic                 wr_valid,
  input  sram_ctrl_pkg::addr_t wr_addr,
  input  sram_ctrl_pkg::data_t wr_data,
  input  logic                 wr_pop,
  output logic                 wr_pending,
  output sram_ctrl_pkg::addr_t wr_head_addr,
  output sram_ctrl_pkg::data_t wr_head_data,
  output logic                 wr_credit_return
);
  import sram_ctrl_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // address and data of each queued write
  addr_t addr_mem [FIFO_DEPTH];
  data_t data_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // entries held, one per credit the requester spent
  credit_t count;

  // entry storage
  always_ff @(posedge oe_n) begin
    if (wr_valid) begin
      addr_mem[wr_ptr] <= wr_addr;
      data_mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap on their own for power-of-two depths
  always_ff @(posedge oe_n) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (wr_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= credit_step(count, wr_valid, wr_pop);
    end
  end

  // head entry seen by the sequencer
  assign wr_pending   = (count != '0);
  assign wr_head_addr = addr_mem[rd_ptr];
  assign wr_head_data = data_mem[rd_ptr];

  // entry leaves for the bus in WR_SETUP
  // so the credit goes back in that same cycle
  assign wr_credit_return = wr_pop;

endmodule

`default_nettype wire

// ==== tb_sram_ctrl.sv ====
`default_nettype none

module tb_sram_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import sram_ctrl_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int NUM_WORDS  = 8;
  // worst case per access with defaults, plus turnaround
  localparam int WR_CYCLES  = 5;
  localparam int RD_CYCLES  = 6;
  localparam int TIMEOUT_CYCLES = (NUM_WORDS + FIFO_DEPTH + 1) * WR_CYCLES +
                                  (NUM_WORDS + FIFO_DEPTH + 2) * RD_CYCLES + 50 + 200;

  logic  oe_n, rst;
  logic  wr_valid, rd_valid, rsp_credit;
  addr_t wr_addr, rd_addr;
  data_t wr_data;
  logic  wr_credit_return, rd_credit_return, rsp_valid;
  data_t rsp_data;
  logic  sram_ce_b, sram_we_b, sram_oe_b;
  addr_t sram_addr;
  wire data_t sram_data;

  // requester credit state and counters
  int wr_credits, rd_credits;
  int wr_ret_count, rd_ret_count, rsp_count;
  int errors;
  int cycles;
  logic [31:0] seed;

  // scoreboard and expected responses in order
  data_t sb_mem [1 << ADDR_W];
  data_t exp_q [$];
  addr_t addr_list [NUM_WORDS];

  // accepted write addresses in bus order
  addr_t wr_addr_q [$];
  logic  we_low_prev;

  sram_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (
    .oe_n(oe_n), .rst(rst),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
    .wr_credit_return(wr_credit_return),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_credit_return(rd_credit_return),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_credit(rsp_credit),
    .sram_ce_b(sram_ce_b), .sram_we_b(sram_we_b), .sram_oe_b(sram_oe_b),
    .sram_addr(sram_addr), .sram_data(sram_data)
  );

  sram_async_model u_sram (
    .rst(rst), .sram_ce_b(sram_ce_b), .sram_we_b(sram_we_b),
    .sram_oe_b(sram_oe_b), .sram_addr(sram_addr), .sram_data(sram_data)
  );

  initial begin
    oe_n = 1'b0;
    forever #5 oe_n = ~oe_n;
  end

  // lcg step
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // hang guard
  always @(posedge oe_n) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // credit and response monitor, outputs stable at negedge
  always @(negedge oe_n) begin
    if (!rst) begin
      if (wr_credit_return) begin
        wr_credits++;
        wr_ret_count++;
      end
      if (rd_credit_return) begin
        rd_credits++;
        rd_ret_count++;
      end
      if (wr_credits > FIFO_DEPTH || rd_credits > FIFO_DEPTH) begin
        $display("more credits returned than were granted");
        errors++;
      end
      // each write pulse carries the oldest accepted write address
      if (sram_we_b === 1'b0 && !we_low_prev) begin
        if (wr_addr_q.size() == 0) begin
          $display("write pulse on the bus with no write outstanding");
          errors++;
        end else begin
          if (sram_addr !== wr_addr_q[0]) begin
            $display("Error: sram_addr got %h expected %h", sram_addr, wr_addr_q[0]);
            errors++;
          end
          void'(wr_addr_q.pop_front());
        end
      end
      we_low_prev = (sram_we_b === 1'b0);
      if (rsp_valid) begin
        rsp_count++;
        if (exp_q.size() == 0) begin
          $display("response arrived with no read outstanding");
          errors++;
        end else if (rsp_data !== exp_q[0]) begin
          $display("Error: rsp_data got %h expected %h", rsp_data, exp_q[0]);
          errors++;
          void'(exp_q.pop_front());
        end else begin
          void'(exp_q.pop_front());
        end
      end
    end
  end

  task automatic send_write(input addr_t a, input data_t d);
    while (wr_credits == 0) @(negedge oe_n);
    wr_valid = 1'b1;
    wr_addr  = a;
    wr_data  = d;
    wr_credits--;
    sb_mem[a] = d;
    wr_addr_q.push_back(a);
    @(negedge oe_n);
    wr_valid = 1'b0;
  endtask

  task automatic send_read(input addr_t a);
    while (rd_credits == 0) @(negedge oe_n);
    rd_valid = 1'b1;
    rd_addr  = a;
    rd_credits--;
    exp_q.push_back(sb_mem[a]);
    @(negedge oe_n);
    rd_valid = 1'b0;
  endtask

  task automatic give_rsp_credits(input int n);
    repeat (n) begin
      rsp_credit = 1'b1;
      @(negedge oe_n);
    end
    rsp_credit = 1'b0;
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0) @(negedge oe_n);
  endtask

  task automatic reset_state();
    repeat (3) begin
      @(negedge oe_n);
      if (sram_ce_b !== 1'b1 || sram_we_b !== 1'b1 || sram_oe_b !== 1'b1) begin
        $display("Error: strobes got %h%h%h expected 111", sram_ce_b, sram_we_b, sram_oe_b);
        errors++;
      end
      if (rsp_valid !== 1'b0) begin
        $display("Error: rsp_valid got %h expected 0", rsp_valid);
        errors++;
      end
    end
    if (wr_ret_count != 0 || rd_ret_count != 0) begin
      $display("credit pulses seen while idle after reset");
      errors++;
    end
  endtask

  task automatic write_then_read();
    for (int i = 0; i < NUM_WORDS; i++) begin
      addr_list[i] = addr_t'(i * 67 + 5);
      send_write(addr_list[i], data_t'(next_rand() >> 8));
    end
    give_rsp_credits(NUM_WORDS);
    for (int i = 0; i < NUM_WORDS; i++) begin
      send_read(addr_list[i]);
    end
    wait_responses();
  endtask

  task automatic credit_accounting();
    int ret_before;
    while (wr_credits != FIFO_DEPTH) @(negedge oe_n);
    ret_before = wr_ret_count;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      send_write(addr_list[i], data_t'(next_rand() >> 8));
    end
    while (wr_credits != FIFO_DEPTH) @(negedge oe_n);
    // queue drained, no further pulse may follow
    repeat (10) @(negedge oe_n);
    if (wr_ret_count - ret_before != FIFO_DEPTH) begin
      $display("Error: wr_credit_return count got %h expected %h",
               wr_ret_count - ret_before, FIFO_DEPTH);
      errors++;
    end
  endtask

  task automatic write_priority();
    give_rsp_credits(1);
    while (wr_credits == 0 || rd_credits == 0) @(negedge oe_n);
    // same cycle, same address
    wr_valid = 1'b1;
    wr_addr  = addr_list[1];
    wr_data  = data_t'(next_rand() >> 8);
    rd_valid = 1'b1;
    rd_addr  = addr_list[1];
    wr_credits--;
    rd_credits--;
    sb_mem[addr_list[1]] = wr_data;
    wr_addr_q.push_back(addr_list[1]);
    exp_q.push_back(wr_data);
    @(negedge oe_n);
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    wait_responses();
  endtask

  task automatic response_backpressure();
    int rsp_before;
    while (rd_credits != FIFO_DEPTH) @(negedge oe_n);
    rsp_before = rsp_count;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      send_read(addr_list[NUM_WORDS - 1 - i]);
    end
    repeat (20) @(negedge oe_n);
    if (rsp_count != rsp_before) begin
      $display("response delivered without a response credit");
      errors++;
    end
    if (rd_credits != 0) begin
      $display("read credits returned while responses were blocked");
      errors++;
    end
    give_rsp_credits(FIFO_DEPTH);
    wait_responses();
  endtask

  task automatic single_read_latency();
    int lat;
    repeat (3) @(negedge oe_n);
    give_rsp_credits(1);
    repeat (2) @(negedge oe_n);
    send_read(addr_list[2]);
    lat = 1;
    while (!rsp_valid && lat < 50) begin
      @(negedge oe_n);
      lat++;
    end
    if (lat != 5) begin
      $display("Error: read latency got %h expected %h", lat, 5);
      errors++;
    end
    wait_responses();
  endtask

  initial begin
    seed = 32'd35942;
    errors = 0;
    cycles = 0;
    wr_credits = FIFO_DEPTH;
    rd_credits = FIFO_DEPTH;
    wr_ret_count = 0;
    rd_ret_count = 0;
    rsp_count = 0;
    we_low_prev = 1'b0;
    rst = 1'b1;
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    rsp_credit = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_addr = '0;
    repeat (3) @(posedge oe_n);
    @(negedge oe_n);
    rst = 1'b0;
    reset_state();
    write_then_read();
    credit_accounting();
    write_priority();
    response_backpressure();
    single_read_latency();
    repeat (5) @(negedge oe_n);
    $display("run complete, %0d errors, %0d responses", errors, rsp_count);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
